//--- tb.f
logic/mipsPkg.sv
logic/Registers.sv
logic/InstrDecoder.sv
logic/IntAlu.sv
logic/ExecCore.sv
verif/ExecCoreTb.sv

//--- Makefile
SIM      := verilator
TOP      := ExecCoreTb
FILELIST := tb.f
SIMFLAGS := --binary --timing --assert --timescale 1ns/100ps -j 0
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "^Everything OK$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verif/ExecCoreTb.sv
module ExecCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    import mipsPkg::*;

    typedef struct packed {
        logic    known;     // Legal encoding so destination and value count
        retire_t ret;
    } expect_t;

    logic    clk;
    logic    reset;
    logic    instrValid;
    word_t   instr;
    logic    retireValid;
    retire_t retire;

    word_t   model [0:31];  // Reference register state
    expect_t expQ [$];
    expect_t expRet;
    logic    expValid;
    int      seed;
    int      errorCount = 0;
    int      issueCount = 0;
    int      retireCount = 0;

    ExecCore dut (
        .clk         (clk),
        .reset       (reset),
        .instrValid  (instrValid),
        .instr       (instr),
        .retireValid (retireValid),
        .retire      (retire)
    );

    always #5 clk = ~clk;

    function automatic word_t rType(input logic [5:0] fn, input regAddr_t rs,
                                    input regAddr_t rt, input regAddr_t rd,
                                    input logic [4:0] sh);
        return {opSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t iType(input logic [5:0] op, input regAddr_t rs,
                                    input regAddr_t rt, input logic [15:0] imm16);
        return {op, rs, rt, imm16};
    endfunction

    // ISA semantics applied in program order at issue
    task automatic predict(input word_t w, output expect_t e);
        logic [5:0] op;
        logic [5:0] fn;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        regAddr_t   dest;
        logic [4:0] sh;
        word_t      a;
        word_t      b;
        word_t      simm;
        word_t      zimm;
        word_t      value;
        logic       known;
        op = w[31:26];
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        sh = w[10:6];
        fn = w[5:0];
        a = model[rs];
        b = model[rt];
        simm = {{16{w[15]}}, w[15:0]};
        zimm = {16'h0000, w[15:0]};
        value = '0;
        known = 1'b1;
        dest = rd;
        if (op == opSpecial) begin
            case (fn)
                fnAddu:  value = a + b;
                fnSubu:  value = a - b;
                fnAnd:   value = a & b;
                fnOr:    value = a | b;
                fnXor:   value = a ^ b;
                fnNor:   value = ~(a | b);
                fnSlt:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                fnSltu:  value = (a < b) ? 32'd1 : 32'd0;
                fnSll:   value = b << sh;
                fnSrl:   value = b >> sh;
                fnSra:   value = $signed(b) >>> sh;
                fnMovz:  value = (b == '0) ? a : model[rd];
                fnMovn:  value = (b != '0) ? a : model[rd];
                default: known = 1'b0;
            endcase
        end else begin
            dest = rt;
            case (op)
                opAddiu: value = a + simm;
                opSlti:  value = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                opAndi:  value = a & zimm;
                opOri:   value = a | zimm;
                opXori:  value = a ^ zimm;
                opLui:   value = {w[15:0], 16'h0000};
                default: known = 1'b0;
            endcase
        end
        if (known && dest != '0) begin
            model[dest] = value;
        end
        e.known = known;
        e.ret.rdAddr = dest;
        e.ret.rdValue = value;
        e.ret.wrote = known && (dest != '0);
    endtask

    task automatic issue(input word_t w);
        expect_t e;
        @(posedge clk);
        predict(w, e);
        expQ.push_back(e);
        instrValid <= 1'b1;
        instr      <= w;
        issueCount++;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            instrValid <= 1'b0;
            instr      <= $random(seed);  // Decoded but never accepted
        end
    endtask

    task automatic pickReg(output regAddr_t r);
        logic [31:0] v;
        v = $random(seed);
        if (v[5:4] == 2'b00) begin
            r = v[12:8];
        end else begin
            r = {2'b00, v[2:0]};  // Few registers so hazards are common
        end
    endtask

    task automatic randomInstr(output word_t w);
        logic [31:0] v;
        int          kind;
        regAddr_t    rs;
        regAddr_t    rt;
        regAddr_t    rd;
        kind = $unsigned($random(seed)) % 20;
        pickReg(rs);
        pickReg(rt);
        pickReg(rd);
        v = $random(seed);
        case (kind)
            0:  w = rType(fnAddu, rs, rt, rd, 5'd0);
            1:  w = rType(fnSubu, rs, rt, rd, 5'd0);
            2:  w = rType(fnAnd, rs, rt, rd, 5'd0);
            3:  w = rType(fnOr, rs, rt, rd, 5'd0);
            4:  w = rType(fnXor, rs, rt, rd, 5'd0);
            5:  w = rType(fnNor, rs, rt, rd, 5'd0);
            6:  w = rType(fnSlt, rs, rt, rd, 5'd0);
            7:  w = rType(fnSltu, rs, rt, rd, 5'd0);
            8:  w = rType(fnSll, 5'd0, rt, rd, v[4:0]);
            9:  w = rType(fnSrl, 5'd0, rt, rd, v[4:0]);
            10: w = rType(fnSra, 5'd0, rt, rd, v[4:0]);
            11: w = rType(fnMovz, rs, rt, rd, 5'd0);
            12: w = rType(fnMovn, rs, rt, rd, 5'd0);
            13: w = iType(opAddiu, rs, rt, v[15:0]);
            14: w = iType(opSlti, rs, rt, v[15:0]);
            15: w = iType(opAndi, rs, rt, v[15:0]);
            16: w = iType(opOri, rs, rt, v[15:0]);
            17: w = iType(opXori, rs, rt, v[15:0]);
            18: w = iType(opLui, 5'd0, rt, v[15:0]);
            default: w = v;  // Mostly unknown encodings
        endcase
    endtask

    task automatic runHazards();
        issue(iType(opAddiu, 5'd5, 5'd5, 16'h0001));   // Chain of three on r5
        issue(iType(opAddiu, 5'd5, 5'd5, 16'hfff0));
        issue(rType(fnAddu, 5'd5, 5'd5, 5'd5, 5'd0));
        issue(rType(fnSubu, 5'd5, 5'd4, 5'd6, 5'd0));
        issue(rType(fnSll, 5'd0, 5'd6, 5'd7, 5'd3));
        issue(rType(fnSlt, 5'd7, 5'd6, 5'd8, 5'd0));
        idle(2);
    endtask

    task automatic runMoves();
        issue(iType(opAddiu, 5'd0, 5'd8, 16'h0000));
        issue(rType(fnMovz, 5'd10, 5'd8, 5'd9, 5'd0));  // Moves since rt was just cleared
        issue(rType(fnMovn, 5'd11, 5'd8, 5'd9, 5'd0));  // Keeps r9 from the cycle before
        issue(iType(opOri, 5'd0, 5'd8, 16'h0007));
        issue(rType(fnMovn, 5'd11, 5'd8, 5'd9, 5'd0));
        issue(rType(fnMovz, 5'd12, 5'd8, 5'd9, 5'd0));
        issue(iType(opLui, 5'd0, 5'd13, 16'h8001));
        issue(rType(fnMovn, 5'd14, 5'd0, 5'd13, 5'd0)); // Keeps rd written just before
        idle(1);
        issue(rType(fnMovz, 5'd14, 5'd0, 5'd15, 5'd0));
        idle(2);
    endtask

    task automatic runZeroAndUnknown();
        issue(iType(opAddiu, 5'd1, 5'd0, 16'h1234));
        issue(rType(fnAddu, 5'd2, 5'd3, 5'd0, 5'd0));
        issue(rType(fnOr, 5'd0, 5'd0, 5'd16, 5'd0));
        issue(rType(fnMovz, 5'd17, 5'd18, 5'd0, 5'd0));
        issue(iType(6'h3f, 5'd1, 5'd17, 16'hbeef));     // Unknown opcode aimed at r17
        issue(rType(6'h01, 5'd1, 5'd2, 5'd17, 5'd0));
        issue(iType(6'h23, 5'd2, 5'd17, 16'h0004));     // Load is not supported
        issue(rType(fnAddu, 5'd17, 5'd0, 5'd18, 5'd0));
        idle(2);
    endtask

    // Mirrors the writeback stage timing
    always @(posedge clk) begin
        if (reset) begin
            expValid <= 1'b0;
        end else if (instrValid) begin
            if (expQ.size() == 0) begin
                errorCount++;
                $display("Instruction accepted at %0t with nothing issued", $time);
                expValid <= 1'b0;
            end else begin
                expRet   <= expQ.pop_front();
                expValid <= 1'b1;
            end
        end else begin
            expValid <= 1'b0;
        end
        if (!reset && retireValid) begin
            retireCount <= retireCount + 1;
        end
    end

    a_retireTiming : assert property (
        @(posedge clk) disable iff (reset)
        retireValid == expValid
    ) else begin
        errorCount++;
        $display("Error at %0t: retireValid %b, expected %b", $time,
                 $sampled(retireValid), $sampled(expValid));
    end

    a_wroteFlag : assert property (
        @(posedge clk) disable iff (reset)
        retireValid && expValid |-> retire.wrote == expRet.ret.wrote
    ) else begin
        errorCount++;
        $display("Error at %0t: wrote %b, expected %b", $time,
                 $sampled(retire.wrote), $sampled(expRet.ret.wrote));
    end

    a_destination : assert property (
        @(posedge clk) disable iff (reset)
        retireValid && expValid && expRet.known |-> retire.rdAddr == expRet.ret.rdAddr
    ) else begin
        errorCount++;
        $display("Error at %0t: rdAddr %0d, expected %0d", $time,
                 $sampled(retire.rdAddr), $sampled(expRet.ret.rdAddr));
    end

    a_resultValue : assert property (
        @(posedge clk) disable iff (reset)
        retireValid && expValid && expRet.known |-> retire.rdValue == expRet.ret.rdValue
    ) else begin
        errorCount++;
        $display("Error at %0t: r%0d value %h, expected %h", $time,
                 $sampled(retire.rdAddr), $sampled(retire.rdValue),
                 $sampled(expRet.ret.rdValue));
    end

    a_r0Source : assert property (
        @(posedge clk) disable iff (reset)
        instrValid |-> (dut.dec.rsAddr != '0 || dut.rsVal == '0)
                    && (dut.dec.rtAddr != '0 || dut.rtVal == '0)
    ) else begin
        errorCount++;
        $display("Error at %0t: r0 read as nonzero source", $time);
    end

    initial begin
        logic [31:0] v;
        word_t       w;
        int          i;
        int          cycles;
        seed = 32'he0a8_d61c;
        clk = 1'b0;
        reset <= 1'b1;
        instrValid <= 1'b0;
        instr <= '0;
        for (i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        idle(3);

        for (i = 1; i < 32; i++) begin
            v = $random(seed);
            issue(iType(opAddiu, 5'd0, regAddr_t'(i), v[15:0]));
        end
        idle(1);
        runHazards();
        runMoves();
        runZeroAndUnknown();

        for (i = 0; i < 400; i++) begin
            v = $random(seed);
            if (v[1:0] == 2'b00) begin
                idle(1 + int'(v[3:2]));
            end
            randomInstr(w);
            issue(w);
        end
        idle(1);

        cycles = 0;
        while (retireCount != issueCount && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (retireCount != issueCount) begin
            errorCount++;
            $display("Timed out waiting for the last retire, %0d of %0d retired",
                     retireCount, issueCount);
        end
        @(posedge clk);
        $display("Issued %0d, retired %0d, errors %0d", issueCount, retireCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- logic/ExecCore.sv
module ExecCore (
    input  logic             clk,
    input  logic             reset,
    input  logic             instrValid,
    input  mipsPkg::word_t   instr,
    output logic             retireValid,
    output mipsPkg::retire_t retire
);
    import mipsPkg::*;

    decoded_t dec;
    word_t    rsRaw;
    word_t    rtRaw;
    word_t    rdRaw;
    word_t    rsVal;
    word_t    rtVal;
    word_t    rdVal;
    word_t    aluResult;
    retire_t  nextRet;
    stage_t   stage;
    logic     issueWrite;

    // Newest value of a register, taking the one still in writeback
    function automatic word_t bypass(
        input stage_t   st,
        input regAddr_t addr,
        input word_t    raw
    );
        if (st.valid && st.regWrite && st.ret.rdAddr == addr) begin
            return st.ret.rdValue;
        end
        return raw;
    endfunction

    InstrDecoder decoder (
        .instr (instr),
        .dec   (dec)
    );

    assign issueWrite = instrValid && dec.regWrite;

    Registers regFile (
        .clk           (clk),
        .reset         (reset),
        .regWrite      (issueWrite),
        .readRegister1 (dec.rsAddr),
        .readRegister2 (dec.rtAddr),
        .writeRegister (dec.rdAddr),
        .writeData     (stage.ret.rdValue),
        .readData1     (rsRaw),
        .readData2     (rtRaw),
        .readDataRD    (rdRaw)
    );

    assign rsVal = bypass(stage, dec.rsAddr, rsRaw);
    assign rtVal = bypass(stage, dec.rtAddr, rtRaw);
    assign rdVal = bypass(stage, dec.rdAddr, rdRaw);  // Old rd for MOVZ/MOVN

    IntAlu alu (
        .aluOp  (dec.aluOp),
        .srcA   (rsVal),
        .srcB   (rtVal),
        .oldRd  (rdVal),
        .imm    (dec.imm),
        .useImm (dec.useImm),
        .shamt  (dec.shamt),
        .result (aluResult)
    );

    assign nextRet.rdAddr  = dec.rdAddr;
    assign nextRet.rdValue = aluResult;
    assign nextRet.wrote   = dec.regWrite;

    // Writeback stage, feeds the register write and the retire port
    always_ff @(posedge clk) begin
        if (reset) begin
            stage.valid    <= 1'b0;
            stage.regWrite <= 1'b0;
        end else begin
            stage.valid    <= instrValid;
            stage.regWrite <= dec.regWrite;
        end
        stage.ret <= nextRet;
    end

    assign retireValid = stage.valid;
    assign retire      = stage.ret;

    a_quietAfterReset : assert property (
        @(posedge clk)
        reset |=> !retireValid
    ) else $error("ExecCore: retire right after reset");

    // Decoder and stage together keep r0 out of writeback
    a_wroteNonZero : assert property (
        @(posedge clk) disable iff (reset)
        retireValid && retire.wrote |-> retire.rdAddr != '0
    ) else $error("ExecCore: retired write to r0");

endmodule

//--- logic/IntAlu.sv
module IntAlu (
    input  mipsPkg::aluOp_t aluOp,
    input  mipsPkg::word_t  srcA,
    input  mipsPkg::word_t  srcB,
    input  mipsPkg::word_t  oldRd,
    input  mipsPkg::word_t  imm,
    input  logic            useImm,
    input  logic [4:0]      shamt,
    output mipsPkg::word_t  result
);
    import mipsPkg::*;

    word_t opB;
    logic  srcBZero;
    logic  lessSigned;
    logic  lessUnsigned;

    assign opB      = useImm ? imm : srcB;
    assign srcBZero = (srcB == '0);

    assign lessSigned   = $signed(srcA) < $signed(opB);
    assign lessUnsigned = srcA < opB;

    always_comb begin
        case (aluOp)
            aluAdd: result = srcA + opB;
            aluSub: result = srcA - opB;
            aluAnd: result = srcA & opB;
            aluOr:  result = srcA | opB;
            aluXor: result = srcA ^ opB;
            aluNor: result = ~(srcA | opB);

            aluSlt:  result = {31'd0, lessSigned};
            aluSltu: result = {31'd0, lessUnsigned};

            // Shifts operate on rt
            aluSll: result = srcB << shamt;
            aluSrl: result = srcB >> shamt;
            aluSra: result = $signed(srcB) >>> shamt;

            aluLui: result = {imm[15:0], 16'd0};

            // Failed condition writes the old rd back
            aluMovz: result = srcBZero ? srcA : oldRd;
            aluMovn: result = srcBZero ? oldRd : srcA;

            aluPass: result = opB;
            default: result = '0;
        endcase
    end

endmodule

//--- logic/InstrDecoder.sv
module InstrDecoder (
    input  mipsPkg::word_t    instr,
    output mipsPkg::decoded_t dec
);
    import mipsPkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    regAddr_t    rsField;
    regAddr_t    rtField;
    regAddr_t    rdField;
    word_t       immSext;
    word_t       immZext;
    logic        known;

    assign opcode  = instr[31:26];
    assign rsField = instr[25:21];
    assign rtField = instr[20:16];
    assign rdField = instr[15:11];
    assign funct   = instr[5:0];
    assign imm16   = instr[15:0];

    assign immSext = {{16{imm16[15]}}, imm16};
    assign immZext = {16'd0, imm16};

    always_comb begin
        dec.rsAddr = rsField;
        dec.rtAddr = rtField;
        dec.rdAddr = rdField;
        dec.aluOp  = aluPass;
        dec.useImm = 1'b0;
        dec.imm    = immZext;
        dec.shamt  = instr[10:6];
        known      = 1'b1;

        if (opcode == opSpecial) begin
            case (funct)
                fnSll:   dec.aluOp = aluSll;
                fnSrl:   dec.aluOp = aluSrl;
                fnSra:   dec.aluOp = aluSra;
                fnMovz:  dec.aluOp = aluMovz;
                fnMovn:  dec.aluOp = aluMovn;
                fnAddu:  dec.aluOp = aluAdd;
                fnSubu:  dec.aluOp = aluSub;
                fnAnd:   dec.aluOp = aluAnd;
                fnOr:    dec.aluOp = aluOr;
                fnXor:   dec.aluOp = aluXor;
                fnNor:   dec.aluOp = aluNor;
                fnSlt:   dec.aluOp = aluSlt;
                fnSltu:  dec.aluOp = aluSltu;
                default: known = 1'b0;
            endcase
        end else begin
            // I-type writes rt
            dec.rdAddr = rtField;
            dec.useImm = 1'b1;
            case (opcode)
                opAddiu: begin
                    dec.aluOp = aluAdd;
                    dec.imm   = immSext;
                end
                opSlti: begin
                    dec.aluOp = aluSlt;
                    dec.imm   = immSext;
                end
                opAndi:  dec.aluOp = aluAnd;
                opOri:   dec.aluOp = aluOr;
                opXori:  dec.aluOp = aluXor;
                opLui:   dec.aluOp = aluLui;
                default: begin
                    known      = 1'b0;
                    dec.useImm = 1'b0;
                end
            endcase
        end

        // Unknown encodings and r0 destinations retire without a write
        dec.regWrite = known && (dec.rdAddr != '0);
    end

endmodule

//--- logic/Registers.sv
module Registers (
    input  logic            clk,
    input  logic            reset,
    input  logic            regWrite,
    input  mipsPkg::regAddr_t readRegister1,
    input  mipsPkg::regAddr_t readRegister2,
    input  mipsPkg::regAddr_t writeRegister,
    input  mipsPkg::word_t  writeData,
    output mipsPkg::word_t  readData1,
    output mipsPkg::word_t  readData2,
    output mipsPkg::word_t  readDataRD
);
    import mipsPkg::*;

    word_t    registers [0:31];
    logic     pendWrite;
    regAddr_t pendAddr;

    // Third port reads the destination of the instruction in decode,
    // which is what MOVZ and MOVN keep when their condition fails
    assign readData1  = registers[readRegister1];
    assign readData2  = registers[readRegister2];
    assign readDataRD = registers[writeRegister];

    // Address and enable come with the instruction, the data one cycle later
    // from the writeback stage
    always_ff @(posedge clk) begin
        if (reset) begin
            pendWrite <= 1'b0;
        end else begin
            pendWrite <= regWrite;
        end
        pendAddr <= writeRegister;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            registers[0] <= '0;  // Only r0 is defined after reset
        end else if (pendWrite && pendAddr != '0) begin
            registers[pendAddr] <= writeData;
        end
    end

    // Decoder and core must never request a write to r0
    a_noWriteR0 : assert property (
        @(posedge clk) disable iff (reset)
        regWrite |-> writeRegister != '0
    ) else $error("Registers: write enable with destination r0");

endmodule

//--- logic/mipsPkg.sv
package mipsPkg;

    typedef logic [4:0]  regAddr_t;
    typedef logic [31:0] word_t;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;   // R-type, function field selects
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;

    // Function codes under opSpecial
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnMovz = 6'h0a;
    localparam logic [5:0] fnMovn = 6'h0b;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluNor  = 4'd5,
        aluSlt  = 4'd6,
        aluSltu = 4'd7,
        aluSll  = 4'd8,
        aluSrl  = 4'd9,
        aluSra  = 4'd10,
        aluLui  = 4'd11,
        aluMovz = 4'd12,
        aluMovn = 4'd13,
        aluPass = 4'd14
    } aluOp_t;

    typedef struct packed {
        regAddr_t   rsAddr;
        regAddr_t   rtAddr;
        regAddr_t   rdAddr;     // Destination, rd or rt by format
        aluOp_t     aluOp;
        logic       useImm;
        word_t      imm;        // Already extended
        logic [4:0] shamt;
        logic       regWrite;
    } decoded_t;

    typedef struct packed {
        regAddr_t rdAddr;
        word_t    rdValue;
        logic     wrote;
    } retire_t;

    // Writeback stage contents
    typedef struct packed {
        logic    valid;
        logic    regWrite;
        retire_t ret;
    } stage_t;

endpackage
